//--- rtl/inv_sbox_table.svh
// Inverse S-box table

// indexed by the substituted byte
// one row per high nibble
localparam logic [7:0] inv_sbox [256] = '{
    'h52, 'h09, 'h6a, 'hd5, 'h30, 'h36, 'ha5, 'h38, 'hbf, 'h40, 'ha3, 'h9e, 'h81, 'hf3, 'hd7, 'hfb,
    'h7c, 'he3, 'h39, 'h82, 'h9b, 'h2f, 'hff, 'h87, 'h34, 'h8e, 'h43, 'h44, 'hc4, 'hde, 'he9, 'hcb,
    'h54, 'h7b, 'h94, 'h32, 'ha6, 'hc2, 'h23, 'h3d, 'hee, 'h4c, 'h95, 'h0b, 'h42, 'hfa, 'hc3, 'h4e,
    'h08, 'h2e, 'ha1, 'h66, 'h28, 'hd9, 'h24, 'hb2, 'h76, 'h5b, 'ha2, 'h49, 'h6d, 'h8b, 'hd1, 'h25,
    'h72, 'hf8, 'hf6, 'h64, 'h86, 'h68, 'h98, 'h16, 'hd4, 'ha4, 'h5c, 'hcc, 'h5d, 'h65, 'hb6, 'h92,
    'h6c, 'h70, 'h48, 'h50, 'hfd, 'hed, 'hb9, 'hda, 'h5e, 'h15, 'h46, 'h57, 'ha7, 'h8d, 'h9d, 'h84,
    'h90, 'hd8, 'hab, 'h00, 'h8c, 'hbc, 'hd3, 'h0a, 'hf7, 'he4, 'h58, 'h05, 'hb8, 'hb3, 'h45, 'h06,
    'hd0, 'h2c, 'h1e, 'h8f, 'hca, 'h3f, 'h0f, 'h02, 'hc1, 'haf, 'hbd, 'h03, 'h01, 'h13, 'h8a, 'h6b,
    'h3a, 'h91, 'h11, 'h41, 'h4f, 'h67, 'hdc, 'hea, 'h97, 'hf2, 'hcf, 'hce, 'hf0, 'hb4, 'he6, 'h73,
    'h96, 'hac, 'h74, 'h22, 'he7, 'had, 'h35, 'h85, 'he2, 'hf9, 'h37, 'he8, 'h1c, 'h75, 'hdf, 'h6e,
    'h47, 'hf1, 'h1a, 'h71, 'h1d, 'h29, 'hc5, 'h89, 'h6f, 'hb7, 'h62, 'h0e, 'haa, 'h18, 'hbe, 'h1b,
    'hfc, 'h56, 'h3e, 'h4b, 'hc6, 'hd2, 'h79, 'h20, 'h9a, 'hdb, 'hc0, 'hfe, 'h78, 'hcd, 'h5a, 'hf4,
    'h1f, 'hdd, 'ha8, 'h33, 'h88, 'h07, 'hc7, 'h31, 'hb1, 'h12, 'h10, 'h59, 'h27, 'h80, 'hec, 'h5f,
    'h60, 'h51, 'h7f, 'ha9, 'h19, 'hb5, 'h4a, 'h0d, 'h2d, 'he5, 'h7a, 'h9f, 'h93, 'hc9, 'h9c, 'hef,
    'ha0, 'he0, 'h3b, 'h4d, 'hae, 'h2a, 'hf5, 'hb0, 'hc8, 'heb, 'hbb, 'h3c, 'h83, 'h53, 'h99, 'h61,
    'h17, 'h2b, 'h04, 'h7e, 'hba, 'h77, 'hd6, 'h26, 'he1, 'h69, 'h14, 'h63, 'h55, 'h21, 'h0c, 'h7d
};

//--- rtl/aes_dec_pkg.sv
// AES-256 decryption core definitions
`default_nettype none

package aes_dec_pkg;

    // block and round key width
    localparam int block_bits = 128;

    // state geometry, bytes stored column-major
    localparam int state_bytes = 16;
    localparam int state_rows = 4;

    // AES-256 round count, also the first key address
    localparam int aes_rounds = 14;

    // key address counts 14 down to 0
    localparam int key_addr_bits = 4;

    // serial lookup walks 16 bytes
    localparam int byte_cnt_bits = 4;

    // low byte of the GF(2^8) modulus 11b
    localparam logic [7:0] gf_reduce = 8'h1b;

    // inverse mixing row coefficients 0e 0b 0d 09 by column offset
    localparam logic [3:0] inv_mix_coef [state_rows] = '{4'he, 4'hb, 4'hd, 4'h9};

    // sequencer states
    typedef enum logic [1:0]
    {
        st_idle = 2'd0,
        // waiting for the serial stage of the current round
        st_sub  = 2'd1,
        // copy state to output register
        st_done = 2'd2
    } dec_state_e;

endpackage

`default_nettype wire

//--- rtl/dec_ctrl_if.sv
// Round control interface
`timescale 1ns/1ps
`default_nettype none

interface dec_ctrl_if;

    // ciphertext load, one cycle
    logic load;
    // kicks the serial substitution
    logic sub_start;
    // last round, no column mixing
    logic final_round;
    // state to output register
    logic finish;
    // substituted block ready
    logic sub_done;

    // sequencer side
    modport seq
    (
        output load,
        output sub_start,
        output final_round,
        output finish,
        input  sub_done
    );

    // datapath stages
    modport dp
    (
        input  load,
        input  sub_start,
        input  final_round,
        input  finish,
        output sub_done
    );

endinterface

`default_nettype wire

//--- rtl/dec_sequencer.sv
// Decryption round sequencer
`timescale 1ns/1ps
`default_nettype none

module dec_sequencer
    import aes_dec_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     data_in_valid,
    output logic                     busy,
    output logic [key_addr_bits-1:0] key_addr,
    output logic                     data_out_valid,
    dec_ctrl_if.seq                  ctrl
);

    dec_state_e state;
    logic       accept;

    // new block only taken while idle
    assign accept = (state == st_idle) && data_in_valid;

    // load is combinational so key 14 is applied in the accept cycle
    assign ctrl.load = accept;

    // one cycle in st_done
    assign ctrl.finish = (state == st_done);

    // key 0 round skips InvMixColumns
    assign ctrl.final_round = (state == st_sub) && (key_addr == '0);

    assign busy = (state != st_idle);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state          <= st_idle;
            key_addr       <= key_addr_bits'(aes_rounds);
            ctrl.sub_start <= 1'b0;
            data_out_valid <= 1'b0;
        end
        else
        begin
            // pulses by default
            ctrl.sub_start <= 1'b0;
            // output register was written on the finish edge
            data_out_valid <= (state == st_done);

            case (state)
                st_idle:
                begin
                    if (accept)
                    begin
                        // state holds ct ^ key 14 next cycle
                        state          <= st_sub;
                        key_addr       <= key_addr_bits'(aes_rounds - 1);
                        ctrl.sub_start <= 1'b1;
                    end
                end

                st_sub:
                begin
                    if (ctrl.sub_done)
                    begin
                        if (key_addr == '0)
                        begin
                            // last capture done
                            state <= st_done;
                        end
                        else
                        begin
                            // next round, next key
                            key_addr       <= key_addr - 1'b1;
                            ctrl.sub_start <= 1'b1;
                        end
                    end
                end

                st_done:
                begin
                    state    <= st_idle;
                    // ready for the next ciphertext
                    key_addr <= key_addr_bits'(aes_rounds);
                end

                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/inv_sub_bytes_serial.sv
// Byte-serial inverse S-box stage
`timescale 1ns/1ps
`default_nettype none

module inv_sub_bytes_serial
    import aes_dec_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [block_bits-1:0] shifted,
    output logic [block_bits-1:0] sub_block,
    dec_ctrl_if.dp                ctrl
);

    `include "inv_sbox_table.svh"

    logic [block_bits-1:0]    blk_q;
    logic [block_bits-1:0]    shreg;
    logic [byte_cnt_bits-1:0] cnt;
    logic                     active;
    logic                     rd_en;
    logic                     rd_valid;
    logic                     rd_last;
    logic [7:0]               rom_addr;
    logic [7:0]               rom_q;

    // byte 0 read straight from the input in the start cycle
    assign rom_addr = ctrl.sub_start ? shifted[7:0] : blk_q[8*cnt +: 8];
    assign rd_en = ctrl.sub_start || active;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            cnt           <= '0;
            active        <= 1'b0;
            rd_valid      <= 1'b0;
            rd_last       <= 1'b0;
            ctrl.sub_done <= 1'b0;
        end
        else
        begin
            rd_valid      <= rd_en;
            // rom_q holds byte 15 next cycle
            rd_last       <= active && (cnt == byte_cnt_bits'(state_bytes - 1));
            // last byte lands in the shift register on this edge
            ctrl.sub_done <= rd_last;
            if (ctrl.sub_start)
            begin
                cnt    <= byte_cnt_bits'(1);
                active <= 1'b1;
            end
            else if (active)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == byte_cnt_bits'(state_bytes - 1))
                    active <= 1'b0;
            end
        end
    end

    // block latch, registered ROM read and result shifter
    always_ff @(posedge clk)
    begin
        if (ctrl.sub_start)
            blk_q <= shifted;
        if (rd_en)
            rom_q <= inv_sbox[rom_addr];
        // bytes enter at the top, byte 0 ends at the bottom
        if (rd_valid)
            shreg <= {rom_q, shreg[block_bits-1:8]};
    end

    assign sub_block = shreg;

endmodule

`default_nettype wire

//--- rtl/inv_mix_columns.sv
// Inverse column mixing
`timescale 1ns/1ps
`default_nettype none

module inv_mix_columns
    import aes_dec_pkg::*;
(
    input  logic [block_bits-1:0] data,
    output logic [block_bits-1:0] mixed
);

    // multiply by x, reduce modulo 11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? gf_reduce : 8'h00);
    endfunction

    // small constant multiply by summing x^k multiples
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [3:0] coef);
        logic [7:0] p;
        logic [7:0] acc;
        p   = a;
        acc = '0;
        for (int k = 0; k < 4; k++)
        begin
            if (coef[k])
                acc = acc ^ p;
            p = xtime(p);
        end
        gf_mul = acc;
    endfunction

    always_comb
    begin
        logic [7:0] acc;
        mixed = '0;
        for (int c = 0; c < state_bytes / state_rows; c++)
        begin
            for (int r = 0; r < state_rows; r++)
            begin
                // row r takes 0e a[r], 0b a[r+1], 0d a[r+2], 09 a[r+3]
                acc = '0;
                for (int k = 0; k < state_rows; k++)
                begin
                    acc = acc ^ gf_mul(data[8*(state_rows*c + (r + k) % state_rows) +: 8],
                                       inv_mix_coef[k]);
                end
                mixed[8*(state_rows*c + r) +: 8] = acc;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/state_datapath.sv
// State register and round datapath
`timescale 1ns/1ps
`default_nettype none

module state_datapath
    import aes_dec_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [block_bits-1:0] data_in,
    input  logic [block_bits-1:0] round_key,
    input  logic [block_bits-1:0] sub_in,
    input  logic [block_bits-1:0] mixed,
    output logic [block_bits-1:0] shifted,
    output logic [block_bits-1:0] sub_out_xor,
    output logic [block_bits-1:0] data_out,
    dec_ctrl_if.dp                ctrl
);

    logic [block_bits-1:0] state_q;

    // InvShiftRows, row r rotated right by r columns
    always_comb
    begin
        int src_col;
        shifted = '0;
        for (int c = 0; c < state_bytes / state_rows; c++)
        begin
            for (int r = 0; r < state_rows; r++)
            begin
                src_col = (c + state_rows - r) % state_rows;
                shifted[8*(state_rows*c + r) +: 8] = state_q[8*(state_rows*src_col + r) +: 8];
            end
        end
    end

    // AddRoundKey on the substituted block
    assign sub_out_xor = sub_in ^ round_key;

    // state updates, key comes back for the current key_addr
    always_ff @(posedge clk)
    begin
        if (ctrl.load)
        begin
            // initial AddRoundKey with key 14
            state_q <= data_in ^ round_key;
        end
        else if (ctrl.sub_done)
        begin
            // final round keeps the plain AddRoundKey result
            if (ctrl.final_round)
                state_q <= sub_out_xor;
            else
                state_q <= mixed;
        end
    end

    // output register, held until the next block completes
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data_out <= '0;
        end
        else if (ctrl.finish)
        begin
            data_out <= state_q;
        end
    end

endmodule

`default_nettype wire

//--- rtl/aes256_dec_top.sv
// AES-256 decryption core top
`timescale 1ns/1ps
`default_nettype none

module aes256_dec_top
    import aes_dec_pkg::*;
(
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     data_in_valid,
    input  logic [block_bits-1:0]    data_in,
    input  logic [block_bits-1:0]    round_key,
    output logic [block_bits-1:0]    data_out,
    output logic                     data_out_valid,
    output logic                     busy,
    output logic [key_addr_bits-1:0] key_addr
);

    // stage to stage buses
    logic [block_bits-1:0] shifted;
    logic [block_bits-1:0] sub_block;
    logic [block_bits-1:0] sub_out_xor;
    logic [block_bits-1:0] mixed;

    // round control shared by all stages
    dec_ctrl_if u_ctrl ();

    dec_sequencer u_dec_sequencer (
        .clk            (clk),
        .resetn         (resetn),
        .data_in_valid  (data_in_valid),
        .busy           (busy),
        .key_addr       (key_addr),
        .data_out_valid (data_out_valid),
        .ctrl           (u_ctrl.seq)
    );

    state_datapath u_state_datapath (
        .clk         (clk),
        .resetn      (resetn),
        .data_in     (data_in),
        .round_key   (round_key),
        .sub_in      (sub_block),
        .mixed       (mixed),
        .shifted     (shifted),
        .sub_out_xor (sub_out_xor),
        .data_out    (data_out),
        .ctrl        (u_ctrl.dp)
    );

    // one byte per cycle, 17 cycles per block
    inv_sub_bytes_serial u_inv_sub_bytes_serial (
        .clk       (clk),
        .resetn    (resetn),
        .shifted   (shifted),
        .sub_block (sub_block),
        .ctrl      (u_ctrl.dp)
    );

    inv_mix_columns u_inv_mix_columns (
        .data  (sub_out_xor),
        .mixed (mixed)
    );

endmodule

`default_nettype wire

//--- bench/aes256_dec_assert.sv
// Top-level protocol assertions
`timescale 1ns/1ps
`default_nettype none

module aes256_dec_assert
    import aes_dec_pkg::*;
(
    input logic                     clk,
    input logic                     resetn,
    input logic                     data_in_valid,
    input logic                     data_out_valid,
    input logic                     busy,
    input logic [key_addr_bits-1:0] key_addr
);

    // completion is a single-cycle pulse
    a_valid_pulse: assert property (@(posedge clk) disable iff (!resetn)
        data_out_valid |=> !data_out_valid)
        else $error("data_out_valid held for more than one cycle");

    // core already idle when the result appears
    a_valid_idle: assert property (@(posedge clk) disable iff (!resetn)
        data_out_valid |-> !busy)
        else $error("busy still high with data_out_valid");

    a_key_range: assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= key_addr_bits'(aes_rounds))
        else $error("key_addr above the last round key");

    // accepted block makes the core busy
    a_busy_rise: assert property (@(posedge clk) disable iff (!resetn)
        (!busy && data_in_valid) |=> busy)
        else $error("busy did not rise after an accepted block");

endmodule

bind aes256_dec_top aes256_dec_assert u_aes256_dec_assert (
    .clk            (clk),
    .resetn         (resetn),
    .data_in_valid  (data_in_valid),
    .data_out_valid (data_out_valid),
    .busy           (busy),
    .key_addr       (key_addr)
);

`default_nettype wire

//--- bench/tb_aes256_dec.sv
// AES-256 decryption core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_aes256_dec
    import aes_dec_pkg::*;
();

    `include "inv_sbox_table.svh"

    // twelve blocks plus one idle slot in test 5
    localparam int total_blocks = 13;
    localparam int block_cycles = 300;
    localparam int clk_period = 40;

    logic                     clk;
    logic                     resetn;
    logic                     data_in_valid;
    logic [block_bits-1:0]    data_in;
    logic [block_bits-1:0]    round_key;
    logic [block_bits-1:0]    data_out;
    logic                     data_out_valid;
    logic                     busy;
    logic [key_addr_bits-1:0] key_addr;

    // outside round key memory
    logic [block_bits-1:0]    key_mem [aes_rounds+1];
    logic [block_bits-1:0]    exp_q [$];
    logic [key_addr_bits-1:0] addr_trace [$];
    logic                     trace_on;
    integer                   seed = 32'h25d;
    int                       errors;
    int                       out_count;
    int                       tests_run;

    aes256_dec_top u_aes256_dec_top (
        .clk            (clk),
        .resetn         (resetn),
        .data_in_valid  (data_in_valid),
        .data_in        (data_in),
        .round_key      (round_key),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy),
        .key_addr       (key_addr)
    );

    // key answered in the same cycle
    assign round_key = key_mem[key_addr];

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // GF(2^8) product by shift and add
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        p = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ a;
            a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // plain inverse cipher over the current key memory
    function automatic logic [block_bits-1:0] ref_inv_cipher(input logic [block_bits-1:0] ct);
        logic [7:0]            s [16];
        logic [7:0]            t [16];
        logic [block_bits-1:0] res;
        for (int i = 0; i < 16; i++)
            s[i] = ct[8*i +: 8] ^ key_mem[aes_rounds][8*i +: 8];
        for (int rnd = aes_rounds - 1; rnd >= 0; rnd--)
        begin
            // InvShiftRows and InvSubBytes then AddRoundKey per byte
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    t[4*c+r] = inv_sbox[s[4*((c + 4 - r) % 4) + r]] ^ key_mem[rnd][8*(4*c+r) +: 8];
            if (rnd > 0)
            begin
                for (int c = 0; c < 4; c++)
                    for (int r = 0; r < 4; r++)
                        s[4*c+r] = gmul(t[4*c+r], 8'h0e) ^ gmul(t[4*c+(r+1)%4], 8'h0b)
                                 ^ gmul(t[4*c+(r+2)%4], 8'h0d) ^ gmul(t[4*c+(r+3)%4], 8'h09);
            end
            else
                s = t;
        end
        for (int i = 0; i < 16; i++)
            res[8*i +: 8] = s[i];
        return res;
    endfunction

    task automatic check_val(input string name, input logic [block_bits-1:0] got,
                             input logic [block_bits-1:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch %0s: expected %0h got %0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic rand_block(output logic [block_bits-1:0] v);
        v = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic rand_keys();
        for (int i = 0; i <= aes_rounds; i++)
            rand_block(key_mem[i]);
    endtask

    // one-cycle valid once the core is idle
    task automatic send_block(input logic [block_bits-1:0] ct);
        @(negedge clk);
        while (busy)
            @(negedge clk);
        exp_q.push_back(ref_inv_cipher(ct));
        data_in = ct;
        data_in_valid = 1'b1;
        @(negedge clk);
        data_in_valid = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (out_count < target && n < block_cycles)
        begin
            @(posedge clk);
            n++;
        end
        assert (out_count >= target)
        else
        begin
            $display("block did not complete within %0d cycles", block_cycles);
            errors++;
            exp_q.delete();
        end
        @(negedge clk);
    endtask

    task automatic run_block(input logic [block_bits-1:0] ct);
        int target;
        target = out_count + 1;
        send_block(ct);
        wait_done(target);
    endtask

    task automatic report_test(input string name, input int start_err);
        tests_run++;
        $display("test %0d %0s: %0s", tests_run, name, (errors == start_err) ? "ok" : "failed");
    endtask

    // compare once per completion pulse
    always @(negedge clk)
    begin
        logic [block_bits-1:0] expected;
        if (resetn && data_out_valid)
        begin
            out_count++;
            assert (exp_q.size() > 0)
            else
            begin
                $display("data_out_valid pulsed with no block outstanding");
                errors++;
            end
            if (exp_q.size() > 0)
            begin
                expected = exp_q.pop_front();
                check_val("data_out", data_out, expected);
            end
        end
    end

    // key address sampled at each edge of a block
    always @(posedge clk)
    begin
        if (trace_on && (busy || data_in_valid))
        begin
            if (addr_trace.size() == 0 || addr_trace[$] != key_addr)
                addr_trace.push_back(key_addr);
        end
    end

    initial
    begin
        logic [block_bits-1:0] ct;
        logic [block_bits-1:0] ct2;
        int                    start_err;
        int                    start_cnt;
        resetn = 1'b0;
        data_in_valid = 1'b0;
        data_in = '0;
        trace_on = 1'b0;
        errors = 0;
        out_count = 0;
        tests_run = 0;
        for (int i = 0; i <= aes_rounds; i++)
            key_mem[i] = '0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;

        // reset values
        start_err = errors;
        @(negedge clk);
        check_val("data_out_valid", data_out_valid, 0);
        check_val("busy", busy, 0);
        check_val("key_addr", key_addr, aes_rounds);
        check_val("data_out", data_out, 0);
        report_test("reset state", start_err);

        start_err = errors;
        rand_keys();
        rand_block(ct);
        run_block(ct);
        report_test("single random block", start_err);

        // no key influence
        start_err = errors;
        for (int i = 0; i <= aes_rounds; i++)
            key_mem[i] = '0;
        run_block('0);
        report_test("zero block and keys", start_err);

        start_err = errors;
        rand_keys();
        repeat (8)
        begin
            rand_block(ct);
            run_block(ct);
        end
        report_test("eight blocks back to back", start_err);

        // second valid lands mid block
        start_err = errors;
        start_cnt = out_count;
        rand_block(ct);
        rand_block(ct2);
        send_block(ct);
        repeat (5) @(negedge clk);
        data_in = ct2;
        data_in_valid = 1'b1;
        @(negedge clk);
        data_in_valid = 1'b0;
        wait_done(start_cnt + 1);
        repeat (block_cycles) @(posedge clk);
        check_val("data_out_valid count", out_count - start_cnt, 1);
        report_test("valid while busy ignored", start_err);

        start_err = errors;
        addr_trace.delete();
        trace_on = 1'b1;
        rand_block(ct);
        run_block(ct);
        trace_on = 1'b0;
        check_val("key_addr trace length", addr_trace.size(), aes_rounds + 1);
        for (int i = 0; i < addr_trace.size() && i <= aes_rounds; i++)
            check_val("key_addr", addr_trace[i], aes_rounds - i);
        report_test("key address order", start_err);

        $display("tests %0d, outputs %0d, errors %0d", tests_run, out_count, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // bound from the block count and the per-block limit
    initial
    begin
        #(total_blocks * block_cycles * clk_period + 100 * clk_period);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/aes_dec_pkg.sv
rtl/dec_ctrl_if.sv
rtl/dec_sequencer.sv
rtl/inv_sub_bytes_serial.sv
rtl/inv_mix_columns.sv
rtl/state_datapath.sv
rtl/aes256_dec_top.sv
bench/aes256_dec_assert.sv
bench/tb_aes256_dec.sv

//--- Bender.yml
package:
  name: aes256_dec

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/aes_dec_pkg.sv
      - rtl/dec_ctrl_if.sv
      - rtl/dec_sequencer.sv
      - rtl/inv_sub_bytes_serial.sv
      - rtl/inv_mix_columns.sv
      - rtl/state_datapath.sv
      - rtl/aes256_dec_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/aes256_dec_assert.sv
      - bench/tb_aes256_dec.sv
